// File: rtl/ex_params.svh
// Width and latency macros for the execute stage, included by every RTL and testbench file

`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// Data path width of the core
`define EX_XLEN 32

// Register file address width covering the integer and the extra register space
`define EX_RADDR_W 6

// Stall cycles of a MULH or MULHU request
// Counted from the request cycle up to the cycle before the result is ready
`define EX_MULH_CYCLES 3

`endif

// File: rtl/ex_op_pkg.sv
// Operation encodings of the execute stage, imported by the units and the testbench

`default_nettype none

package ex_op_pkg;

  // ALU operators
  // Arithmetic and logic first, then set-less-than, then the branch compares
  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_AND  = 5'd2,
    ALU_OR   = 5'd3,
    ALU_XOR  = 5'd4,
    ALU_SLT  = 5'd5,
    ALU_SLTU = 5'd6,
    ALU_EQ   = 5'd7,
    ALU_NE   = 5'd8,
    ALU_LT   = 5'd9,
    ALU_GE   = 5'd10,
    ALU_LTU  = 5'd11,
    ALU_GEU  = 5'd12
  } alu_op_e;

  // Multiplier operators
  typedef enum logic [1:0] {
    MUL_MUL   = 2'd0,
    MUL_MULH  = 2'd1,
    MUL_MULHU = 2'd2
  } mul_op_e;

  // Multicycle FSM states of the multiplier
  typedef enum logic [1:0] {
    MULT_IDLE = 2'd0,
    MULT_CALC = 2'd1,
    MULT_DONE = 2'd2
  } mult_state_e;

endpackage

`default_nettype wire

// File: rtl/ex_port_pkg.sv
// Packed bundles for the execute-stage requests and register-file ports, shared with the testbench

`default_nettype none

`include "ex_params.svh"

package ex_port_pkg;

  import ex_op_pkg::*;

  // ALU request from the ID/EX register
  typedef struct packed {
    logic                en;
    alu_op_e             op;
    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
  } alu_req_t;

  // Multiplier request from the ID/EX register
  typedef struct packed {
    logic                en;
    mul_op_e             op;
    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
  } mult_req_t;

  // One register-file write port
  typedef struct packed {
    logic                   we;
    logic [`EX_RADDR_W-1:0] waddr;
    logic [`EX_XLEN-1:0]    wdata;
  } rf_wport_t;

  // Write-back targets handed over from decode
  typedef struct packed {
    logic                   alu_we;
    logic [`EX_RADDR_W-1:0] alu_waddr;
    logic                   lsu_we;
    logic [`EX_RADDR_W-1:0] lsu_waddr;
  } id_wb_t;

endpackage

`default_nettype wire

// File: rtl/ex_alu.sv
// Single-cycle ALU of the execute stage, computes arithmetic, logic and branch compares

`timescale 1ns/100ps
`default_nettype none

`include "ex_params.svh"

module ex_alu
  import ex_op_pkg::*;
  import ex_port_pkg::*;
(
  input  alu_req_t            alu_req_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                cmp_o
);

  localparam int MSB = `EX_XLEN - 1;

  // Shared subtractor with the carry out in the top bit
  logic [`EX_XLEN:0]   sub_res;
  logic [`EX_XLEN-1:0] add_res;
  logic                lt_u;
  logic                lt_s;
  logic                eq;
  logic                is_cmp;
  logic                cmp;

  ////////////////////////////////////////////////////////////
  // Adder and subtractor
  ////////////////////////////////////////////////////////////

  assign add_res = alu_req_i.a + alu_req_i.b;

  // No borrow out of a + ~b + 1 means a >= b unsigned
  assign sub_res = {1'b0, alu_req_i.a} + {1'b0, ~alu_req_i.b}
                   + {{`EX_XLEN{1'b0}}, 1'b1};

  assign lt_u = ~sub_res[`EX_XLEN];

  // Different signs decide by the sign of a, same signs by the difference
  assign lt_s = (alu_req_i.a[MSB] ^ alu_req_i.b[MSB]) ? alu_req_i.a[MSB]
                                                      : sub_res[MSB];

  // Zero difference means equal operands
  assign eq = ~|sub_res[MSB:0];

  ////////////////////////////////////////////////////////////
  // Operator select
  ////////////////////////////////////////////////////////////

  always_comb begin
    result_o = '0;
    cmp      = 1'b0;
    is_cmp   = 1'b1;
    unique case (alu_req_i.op)
      ALU_ADD: begin
        result_o = add_res;
        is_cmp   = 1'b0;
      end
      ALU_SUB: begin
        result_o = sub_res[MSB:0];
        is_cmp   = 1'b0;
      end
      ALU_AND: begin
        result_o = alu_req_i.a & alu_req_i.b;
        is_cmp   = 1'b0;
      end
      ALU_OR: begin
        result_o = alu_req_i.a | alu_req_i.b;
        is_cmp   = 1'b0;
      end
      ALU_XOR: begin
        result_o = alu_req_i.a ^ alu_req_i.b;
        is_cmp   = 1'b0;
      end
      // Compares give the flag zero-extended as result
      ALU_SLT, ALU_LT: cmp = lt_s;
      ALU_SLTU, ALU_LTU: cmp = lt_u;
      ALU_EQ: cmp = eq;
      ALU_NE: cmp = ~eq;
      ALU_GE: cmp = ~lt_s;
      ALU_GEU: cmp = ~lt_u;
      default: is_cmp = 1'b0;
    endcase
    if (is_cmp) begin
      result_o = {{MSB{1'b0}}, cmp};
    end
  end

  // Branch decision flag
  assign cmp_o = cmp;

endmodule

`default_nettype wire

// File: rtl/ex_mult.sv
// Execute-stage multiplier, single-cycle MUL and a multicycle FSM for MULH and MULHU

`timescale 1ns/100ps
`default_nettype none

`include "ex_params.svh"

module ex_mult
  import ex_op_pkg::*;
  import ex_port_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  mult_req_t           mult_req_i,
  input  logic                ex_ready_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                ready_o,
  output logic                multicycle_o
);

  localparam int CNT_W = $clog2(`EX_MULH_CYCLES);
  // CALC lasts one cycle less than the stall since the request cycle counts too
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`EX_MULH_CYCLES - 2);

  mult_state_e state_q;
  mult_state_e state_d;
  logic [CNT_W-1:0] cnt_q;

  logic req_high;
  logic req_signed;

  // Operands sign-extended to 33 bits so one signed multiplier serves both
  logic signed [`EX_XLEN:0]     mul_a;
  logic signed [`EX_XLEN:0]     mul_b;
  logic signed [2*`EX_XLEN+1:0] prod;
  logic signed [`EX_XLEN:0]     op_a_q;
  logic signed [`EX_XLEN:0]     op_b_q;
  logic [`EX_XLEN-1:0]          prod_hi_q;

  assign req_high = mult_req_i.en &
                    ((mult_req_i.op == MUL_MULH) | (mult_req_i.op == MUL_MULHU));
  assign req_signed = (mult_req_i.op == MUL_MULH);

  ////////////////////////////////////////////////////////////
  // Shared multiplier
  ////////////////////////////////////////////////////////////

  // Live operands while idle, captured operands during the multicycle op
  always_comb begin
    if (state_q == MULT_IDLE) begin
      mul_a = {req_signed & mult_req_i.a[`EX_XLEN-1], mult_req_i.a};
      mul_b = {req_signed & mult_req_i.b[`EX_XLEN-1], mult_req_i.b};
    end else begin
      mul_a = op_a_q;
      mul_b = op_b_q;
    end
  end

  assign prod = mul_a * mul_b;

  ////////////////////////////////////////////////////////////
  // High-product FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      MULT_IDLE: if (req_high) state_d = MULT_CALC;
      MULT_CALC: if (cnt_q == CNT_LAST) state_d = MULT_DONE;
      // Hold the result until the stage moves on
      MULT_DONE: if (ex_ready_i) state_d = MULT_IDLE;
      default: state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == MULT_CALC) begin
        cnt_q <= cnt_q + 1'b1;
      end else begin
        cnt_q <= '0;
      end
    end
  end

  // Operand capture on request, high half captured at the end of CALC
  always_ff @(posedge clk) begin
    if ((state_q == MULT_IDLE) && req_high) begin
      op_a_q <= mul_a;
      op_b_q <= mul_b;
    end
    if ((state_q == MULT_CALC) && (cnt_q == CNT_LAST)) begin
      prod_hi_q <= prod[2*`EX_XLEN-1:`EX_XLEN];
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  // Low bits do not depend on the sign extension
  assign result_o = (state_q == MULT_DONE) ? prod_hi_q : prod[`EX_XLEN-1:0];

  // Not ready from the request cycle until DONE
  assign ready_o = (state_q == MULT_DONE) | ((state_q == MULT_IDLE) & ~req_high);

  assign multicycle_o = (state_q != MULT_IDLE);

endmodule

`default_nettype wire

// File: rtl/ex_wb_ctrl.sv
// Execute-stage write-port control, forwarding mux, EX/WB register and stall handshake

`timescale 1ns/100ps
`default_nettype none

`include "ex_params.svh"

module ex_wb_ctrl
  import ex_port_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,

  // Decode hand-over and unit enables
  input  id_wb_t              id_wb_i,
  input  logic                alu_en_i,
  input  logic                mult_en_i,
  input  logic                csr_access_i,
  input  logic                lsu_en_i,

  // Result data
  input  logic [`EX_XLEN-1:0] alu_result_i,
  input  logic [`EX_XLEN-1:0] mult_result_i,
  input  logic [`EX_XLEN-1:0] csr_rdata_i,
  input  logic [`EX_XLEN-1:0] lsu_rdata_i,

  // Stall inputs
  input  logic                mult_ready_i,
  input  logic                lsu_ready_ex_i,
  input  logic                lsu_err_i,
  input  logic                wb_ready_i,
  input  logic                branch_in_ex_i,

  // Write ports and handshake
  output rf_wport_t           alu_wport_o,
  output rf_wport_t           lsu_wport_o,
  output logic                ex_ready_o,
  output logic                ex_valid_o
);

  // EX/WB register
  logic                   lsu_we_q;
  logic [`EX_RADDR_W-1:0] lsu_waddr_q;

  logic units_ready;
  logic lsu_we_next;

  ////////////////////////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////////////////////////

  always_comb begin
    alu_wport_o.we    = id_wb_i.alu_we;
    alu_wport_o.waddr = id_wb_i.alu_waddr;
    // CSR wins over the multiplier, the multiplier over the ALU
    if (csr_access_i) begin
      alu_wport_o.wdata = csr_rdata_i;
    end else if (mult_en_i) begin
      alu_wport_o.wdata = mult_result_i;
    end else if (alu_en_i) begin
      alu_wport_o.wdata = alu_result_i;
    end else begin
      alu_wport_o.wdata = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // EX/WB pipeline register
  ////////////////////////////////////////////////////////////

  // A faulting load never writes back
  assign lsu_we_next = id_wb_i.lsu_we & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q <= 1'b0;
    end else if (ex_valid_o) begin
      lsu_we_q <= lsu_we_next;
    end else if (wb_ready_i) begin
      // WB takes a bubble when nothing leaves EX
      lsu_we_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_o && lsu_we_next) begin
      lsu_waddr_q <= id_wb_i.lsu_waddr;
    end
  end

  // Load data arrives in the WB cycle itself
  assign lsu_wport_o.we    = lsu_we_q;
  assign lsu_wport_o.waddr = lsu_waddr_q;
  assign lsu_wport_o.wdata = lsu_rdata_i;

  ////////////////////////////////////////////////////////////
  // Stall handshake
  ////////////////////////////////////////////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Branches finish in EX, so they release the stage without WB
  assign ex_ready_o = units_ready | branch_in_ex_i;

  // Valid does not look at ex_ready, only at the units and WB
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule

`default_nettype wire

// File: rtl/ex_stage.sv
// Execute-stage top level, connects ALU, multiplier and write-port control for the ID and WB stages

`timescale 1ns/100ps
`default_nettype none

`include "ex_params.svh"

module ex_stage
  import ex_port_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,

  // Requests from the ID/EX register
  input  alu_req_t            alu_req_i,
  input  mult_req_t           mult_req_i,
  input  id_wb_t              id_wb_i,
  input  logic [`EX_XLEN-1:0] alu_operand_c_i,

  // CSR read data
  input  logic                csr_access_i,
  input  logic [`EX_XLEN-1:0] csr_rdata_i,

  // LSU
  input  logic                lsu_en_i,
  input  logic [`EX_XLEN-1:0] lsu_rdata_i,
  input  logic                lsu_ready_ex_i,
  input  logic                lsu_err_i,

  input  logic                branch_in_ex_i,
  input  logic                wb_ready_i,

  // Write ports
  output rf_wport_t           alu_wport_o,
  output rf_wport_t           lsu_wport_o,

  // Branch outcome for IF
  output logic                branch_decision_o,
  output logic [`EX_XLEN-1:0] jump_target_o,

  output logic                mult_multicycle_o,
  output logic                ex_ready_o,
  output logic                ex_valid_o
);

  logic [`EX_XLEN-1:0] alu_result;
  logic [`EX_XLEN-1:0] mult_result;
  logic                mult_ready;

  ////////////////////////////////////////////////////////////
  // Units
  ////////////////////////////////////////////////////////////

  ex_alu alu_inst (
    .alu_req_i (alu_req_i),
    .result_o  (alu_result),
    .cmp_o     (branch_decision_o)
  );

  ex_mult mult_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .mult_req_i   (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  // Write ports and stall control
  ex_wb_ctrl wb_ctrl_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .id_wb_i        (id_wb_i),
    .alu_en_i       (alu_req_i.en),
    .mult_en_i      (mult_req_i.en),
    .csr_access_i   (csr_access_i),
    .lsu_en_i       (lsu_en_i),
    .alu_result_i   (alu_result),
    .mult_result_i  (mult_result),
    .csr_rdata_i    (csr_rdata_i),
    .lsu_rdata_i    (lsu_rdata_i),
    .mult_ready_i   (mult_ready),
    .lsu_ready_ex_i (lsu_ready_ex_i),
    .lsu_err_i      (lsu_err_i),
    .wb_ready_i     (wb_ready_i),
    .branch_in_ex_i (branch_in_ex_i),
    .alu_wport_o    (alu_wport_o),
    .lsu_wport_o    (lsu_wport_o),
    .ex_ready_o     (ex_ready_o),
    .ex_valid_o     (ex_valid_o)
  );

  // Target is computed in ID, passed on to IF with the decision
  assign jump_target_o = alu_operand_c_i;

endmodule

`default_nettype wire

// File: testbench/ex_stage_props.sv
// Concurrent checks on the EX/WB register and WB handshake, bound into ex_stage by the testbench

`timescale 1ns/100ps
`default_nettype none

`include "ex_params.svh"

module ex_stage_props
  import ex_port_pkg::*;
(
  input logic                clk,
  input logic                rst_n,
  input id_wb_t              id_wb_i,
  input logic                lsu_err_i,
  input logic [`EX_XLEN-1:0] lsu_rdata_i,
  input logic                wb_ready_i,
  input logic                ex_valid_o,
  input rf_wport_t           lsu_wport_o,
  input logic                mult_multicycle_o
);

  // Number of failed properties
  int unsigned fail_cnt = 0;

  ////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////

  // Valid load without fault shows up on the WB port next cycle
  lsu_capture: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o && id_wb_i.lsu_we && !lsu_err_i |=>
      lsu_wport_o.we && (lsu_wport_o.waddr == $past(id_wb_i.lsu_waddr)) &&
      (lsu_wport_o.wdata == lsu_rdata_i))
    else begin
      fail_cnt++;
      $error("load write-back missing or with wrong address or data");
    end

  // Faulting load never writes
  lsu_fault: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o && lsu_err_i |=> !lsu_wport_o.we)
    else begin
      fail_cnt++;
      $error("faulting load reached the write-back port");
    end

  // Bubble into WB when nothing leaves EX
  lsu_bubble: assert property (@(posedge clk) disable iff (!rst_n)
    !ex_valid_o && wb_ready_i |=> !lsu_wport_o.we)
    else begin
      fail_cnt++;
      $error("write-back enable not cleared after an idle cycle");
    end

  ////////////////////////////////////////////////////////////
  // Back-pressure and reset
  ////////////////////////////////////////////////////////////

  wb_stall_valid: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |-> !ex_valid_o)
    else begin
      fail_cnt++;
      $error("stage valid while write-back is stalled");
    end

  wb_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> $stable(lsu_wport_o.we) && $stable(lsu_wport_o.waddr))
    else begin
      fail_cnt++;
      $error("write-back register changed while write-back is stalled");
    end

  reset_state: assert property (@(posedge clk)
    $rose(rst_n) |-> !lsu_wport_o.we && !mult_multicycle_o)
    else begin
      fail_cnt++;
      $error("write-back enable or multicycle flag set after reset");
    end

endmodule

`default_nettype wire

// File: testbench/ex_stage_tb.sv
// Testbench for the execute stage, drives random requests on the falling edge and checks results

`timescale 1ns/100ps
`default_nettype none

`include "ex_params.svh"

module ex_stage_tb
  import ex_op_pkg::*;
  import ex_port_pkg::*;
();

  // Combinational outputs are read this long after the falling edge
  localparam int SETTLE_NS   = 20;
  localparam int STALL_LIMIT = 20;

  logic                   clk;
  logic                   rst_n;
  alu_req_t               alu_req;
  mult_req_t              mult_req;
  id_wb_t                 id_wb;
  logic [`EX_XLEN-1:0]    operand_c;
  logic                   csr_access;
  logic [`EX_XLEN-1:0]    csr_rdata;
  logic                   lsu_en;
  logic [`EX_XLEN-1:0]    lsu_rdata;
  logic                   lsu_ready_ex;
  logic                   lsu_err;
  logic                   branch_in_ex;
  logic                   wb_ready;
  rf_wport_t              alu_wport;
  rf_wport_t              lsu_wport;
  logic                   branch_decision;
  logic [`EX_XLEN-1:0]    jump_target;
  logic                   mult_multicycle;
  logic                   ex_ready;
  logic                   ex_valid;

  // Stimulus scratch values
  logic [`EX_XLEN-1:0]    a;
  logic [`EX_XLEN-1:0]    b;
  logic [31:0]            rnd;
  logic [`EX_RADDR_W-1:0] held_addr;
  alu_op_e                op_sel;
  mul_op_e                mop;
  int                     stall;

  ex_stage ex_stage_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .alu_req_i         (alu_req),
    .mult_req_i        (mult_req),
    .id_wb_i           (id_wb),
    .alu_operand_c_i   (operand_c),
    .csr_access_i      (csr_access),
    .csr_rdata_i       (csr_rdata),
    .lsu_en_i          (lsu_en),
    .lsu_rdata_i       (lsu_rdata),
    .lsu_ready_ex_i    (lsu_ready_ex),
    .lsu_err_i         (lsu_err),
    .branch_in_ex_i    (branch_in_ex),
    .wb_ready_i        (wb_ready),
    .alu_wport_o       (alu_wport),
    .lsu_wport_o       (lsu_wport),
    .branch_decision_o (branch_decision),
    .jump_target_o     (jump_target),
    .mult_multicycle_o (mult_multicycle),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid)
  );

  // Handshake and writeback properties inside every ex_stage
  bind ex_stage ex_stage_props props_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .id_wb_i           (id_wb_i),
    .lsu_err_i         (lsu_err_i),
    .lsu_rdata_i       (lsu_rdata_i),
    .wb_ready_i        (wb_ready_i),
    .ex_valid_o        (ex_valid_o),
    .lsu_wport_o       (lsu_wport_o),
    .mult_multicycle_o (mult_multicycle_o)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////

  // Outcome of a compare operator
  function automatic logic branch_expect(input alu_op_e op, input logic [`EX_XLEN-1:0] x,
                                         input logic [`EX_XLEN-1:0] y);
    case (op)
      ALU_EQ: return x == y;
      ALU_NE: return x != y;
      ALU_SLT, ALU_LT: return $signed(x) < $signed(y);
      ALU_GE: return $signed(x) >= $signed(y);
      ALU_SLTU, ALU_LTU: return x < y;
      ALU_GEU: return x >= y;
      default: return 1'b0;
    endcase
  endfunction

  // Forwarded data of an ALU operator where compares give the flag zero-extended
  function automatic logic [`EX_XLEN-1:0] alu_expect(input alu_op_e op,
                                                     input logic [`EX_XLEN-1:0] x,
                                                     input logic [`EX_XLEN-1:0] y);
    case (op)
      ALU_ADD: return x + y;
      ALU_SUB: return x - y;
      ALU_AND: return x & y;
      ALU_OR:  return x | y;
      ALU_XOR: return x ^ y;
      default: return {{(`EX_XLEN-1){1'b0}}, branch_expect(op, x, y)};
    endcase
  endfunction

  // Upper half of the full 64-bit product, signed for MULH
  function automatic logic [`EX_XLEN-1:0] mulh_expect(input mul_op_e op,
                                                      input logic [`EX_XLEN-1:0] x,
                                                      input logic [`EX_XLEN-1:0] y);
    logic signed [2*`EX_XLEN-1:0] sx;
    logic signed [2*`EX_XLEN-1:0] sy;
    logic [2*`EX_XLEN-1:0]        full;
    sx = $signed(x);
    sy = $signed(y);
    if (op == MUL_MULH) begin
      full = sx * sy;
    end else begin
      full = {{`EX_XLEN{1'b0}}, x} * {{`EX_XLEN{1'b0}}, y};
    end
    return full[2*`EX_XLEN-1:`EX_XLEN];
  endfunction

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic expect_eq(input string name, input logic [`EX_XLEN-1:0] expected,
                           input logic [`EX_XLEN-1:0] actual);
    assert (actual === expected) else begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      $display("Test failures found");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Test failures found");
    $fatal(1, "stopped on a timeout");
  endtask

  // Idle stage with all units and WB ready
  task automatic clear_inputs();
    alu_req      = '0;
    mult_req     = '0;
    id_wb        = '0;
    operand_c    = '0;
    csr_access   = 1'b0;
    csr_rdata    = '0;
    lsu_en       = 1'b0;
    lsu_rdata    = '0;
    lsu_ready_ex = 1'b1;
    lsu_err      = 1'b0;
    branch_in_ex = 1'b0;
    wb_ready     = 1'b1;
  endtask

  task automatic settle();
    #(SETTLE_NS);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'ha4e4));
    rst_n = 1'b0;
    clear_inputs();
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    settle();
    expect_eq("reset_lsu_we", 0, lsu_wport.we);
    expect_eq("reset_multicycle", 0, mult_multicycle);

    // ALU arithmetic, logic and set-less-than
    for (int i = 0; i <= int'(ALU_SLTU); i++) begin
      op_sel = alu_op_e'(i);
      repeat (4) begin
        @(negedge clk);
        a       = $urandom();
        b       = $urandom();
        rnd     = $urandom();
        id_wb   = rnd[$bits(id_wb_t)-1:0];
        alu_req = '{en: 1'b1, op: op_sel, a: a, b: b};
        settle();
        expect_eq(op_sel.name(), alu_expect(op_sel, a, b), alu_wport.wdata);
        expect_eq("alu_port_we", id_wb.alu_we, alu_wport.we);
        expect_eq("alu_port_waddr", id_wb.alu_waddr, alu_wport.waddr);
      end
    end

    // Branch compares where the first pass of each uses equal operands
    for (int i = int'(ALU_EQ); i <= int'(ALU_GEU); i++) begin
      op_sel = alu_op_e'(i);
      for (int k = 0; k < 4; k++) begin
        @(negedge clk);
        a            = $urandom();
        b            = (k == 0) ? a : $urandom();
        operand_c    = $urandom();
        branch_in_ex = 1'b1;
        alu_req      = '{en: 1'b1, op: op_sel, a: a, b: b};
        settle();
        expect_eq(op_sel.name(), branch_expect(op_sel, a, b), branch_decision);
        expect_eq("jump_target", operand_c, jump_target);
      end
    end
    @(negedge clk);
    wb_ready = 1'b0;
    settle();
    expect_eq("branch_ready_wb_stall", 1, ex_ready);
    expect_eq("branch_valid_wb_stall", 0, ex_valid);

    // Single-cycle low product
    @(negedge clk);
    clear_inputs();
    a        = $urandom();
    b        = $urandom();
    mult_req = '{en: 1'b1, op: MUL_MUL, a: a, b: b};
    settle();
    expect_eq("MUL", a * b, alu_wport.wdata);
    expect_eq("MUL_ready", 1, ex_ready);
    expect_eq("MUL_valid", 1, ex_valid);

    // High products stall the stage
    for (int i = int'(MUL_MULH); i <= int'(MUL_MULHU); i++) begin
      mop = mul_op_e'(i);
      repeat (3) begin
        @(negedge clk);
        a        = $urandom();
        b        = $urandom();
        mult_req = '{en: 1'b1, op: mop, a: a, b: b};
        settle();
        stall = 0;
        while (!ex_ready) begin
          if (stall >= STALL_LIMIT) begin
            abort_on_timeout("ex_ready after a high multiply");
          end
          if (stall > 0) begin
            expect_eq("mulh_multicycle", 1, mult_multicycle);
          end
          stall++;
          @(negedge clk);
          settle();
        end
        expect_eq("mulh_stall_cycles", `EX_MULH_CYCLES, stall);
        expect_eq("mulh_release_multicycle", 1, mult_multicycle);
        expect_eq(mop.name(), mulh_expect(mop, a, b), alu_wport.wdata);
      end
    end

    // CSR data wins over ALU and multiplier
    @(negedge clk);
    clear_inputs();
    csr_access = 1'b1;
    csr_rdata  = $urandom();
    alu_req    = '{en: 1'b1, op: ALU_ADD, a: $urandom(), b: $urandom()};
    settle();
    expect_eq("csr_over_alu", csr_rdata, alu_wport.wdata);
    @(negedge clk);
    alu_req   = '0;
    csr_rdata = $urandom();
    mult_req  = '{en: 1'b1, op: MUL_MUL, a: $urandom(), b: $urandom()};
    settle();
    expect_eq("csr_over_mult", csr_rdata, alu_wport.wdata);

    // Load write-back one cycle after a valid EX
    @(negedge clk);
    clear_inputs();
    rnd             = $urandom();
    held_addr       = rnd[`EX_RADDR_W-1:0];
    lsu_en          = 1'b1;
    id_wb.lsu_we    = 1'b1;
    id_wb.lsu_waddr = held_addr;
    settle();
    expect_eq("lsu_ex_valid", 1, ex_valid);
    @(negedge clk);
    clear_inputs();
    lsu_rdata = $urandom();
    settle();
    expect_eq("lsu_wb_we", 1, lsu_wport.we);
    expect_eq("lsu_wb_waddr", held_addr, lsu_wport.waddr);
    expect_eq("lsu_wb_wdata", lsu_rdata, lsu_wport.wdata);
    // Idle cycle with WB ready just passed
    @(negedge clk);
    settle();
    expect_eq("lsu_idle_clear", 0, lsu_wport.we);

    // Faulting load
    @(negedge clk);
    lsu_en       = 1'b1;
    id_wb.lsu_we = 1'b1;
    lsu_err      = 1'b1;
    @(negedge clk);
    clear_inputs();
    settle();
    expect_eq("lsu_err_we", 0, lsu_wport.we);

    // WB back-pressure holds the EX/WB register
    @(negedge clk);
    lsu_en          = 1'b1;
    id_wb.lsu_we    = 1'b1;
    id_wb.lsu_waddr = held_addr;
    @(negedge clk);
    id_wb.lsu_waddr = ~held_addr;
    wb_ready        = 1'b0;
    settle();
    expect_eq("wb_stall_valid", 0, ex_valid);
    expect_eq("wb_stall_ready", 0, ex_ready);
    @(negedge clk);
    settle();
    expect_eq("wb_stall_hold_we", 1, lsu_wport.we);
    expect_eq("wb_stall_hold_waddr", held_addr, lsu_wport.waddr);

    // LSU not ready stalls the stage
    @(negedge clk);
    clear_inputs();
    lsu_ready_ex = 1'b0;
    alu_req      = '{en: 1'b1, op: ALU_ADD, a: $urandom(), b: $urandom()};
    settle();
    expect_eq("lsu_stall_valid", 0, ex_valid);
    expect_eq("lsu_stall_ready", 0, ex_ready);
    @(negedge clk);
    clear_inputs();
    repeat (2) @(negedge clk);

    if (ex_stage_inst.props_inst.fail_cnt == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("%0d property checks failed", ex_stage_inst.props_inst.fail_cnt);
      $display("Test failures found");
      $fatal(1, "property failures during the run");
    end
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+rtl
rtl/ex_op_pkg.sv
rtl/ex_port_pkg.sv
rtl/ex_alu.sv
rtl/ex_mult.sv
rtl/ex_wb_ctrl.sv
rtl/ex_stage.sv
testbench/ex_stage_props.sv
testbench/ex_stage_tb.sv

// File: Makefile
# Verilator build and run of the execute-stage testbench

TOP := ex_stage_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f sim.f
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
